// File: pet_lcd.f
src/pet_pkg.sv
src/pet_needs_if.sv
src/pet_needs.sv
src/lcd_mood_writer.sv
src/seg_scan.sv
src/pet_top.sv
sim/pet_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --top-module pet_tb -f pet_lcd.f -o pet_sim
	./obj_dir/pet_sim

clean:
	rm -rf obj_dir

// File: sim/pet_testdata.txt
# name presence vibration feed heal ticks | hunger fun energy happy life mood game_over
# buttons are active low, mood is the mood_t code (0 dead .. 6 happy)
reset     1 1 1 1 0   5 5 5 5 5 6 0
idle16    1 1 1 1 16  3 1 4 4 5 5 0
feed_play 1 0 0 1 2   5 5 2 4 5 4 0
wear      1 1 1 1 15  3 1 1 3 3 4 0
sleep     0 1 1 1 6   3 1 5 3 5 5 0
wear_more 1 1 1 1 10  1 0 4 1 4 2 0
heal      1 1 1 0 1   0 0 4 1 5 2 0
starve    1 1 1 1 41  0 0 2 0 0 0 1
frozen    1 0 0 0 3   0 0 2 0 0 0 1

// File: sim/pet_tb.sv
module pet_tb;

    import pet_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int MAX_STEPS = 32;
    // Inputs change late in a tick period, after the display check
    localparam int DRIVE_OFFSET = 56;
    localparam time TICK_TIME = time'(TICK_CYCLES * CLK_PERIOD);

    // LCD setup bytes and the line 1 cursor address
    localparam int INIT_CMD_COUNT = 3;
    localparam logic [7:0] INIT_BYTES [INIT_CMD_COUNT] = '{8'h38, 8'h0C, 8'h01};
    localparam logic [7:0] CURSOR_CMD = 8'h84;

    typedef logic [0:TEXT_LEN-1][7:0] text_t;

    logic       clk;
    logic       reset;
    logic       ready;
    logic       presence;
    logic       vibration;
    logic       feed;
    logic       heal;
    logic       rs;
    logic       rw;
    logic       e;
    logic [7:0] data;
    logic [6:0] seg;
    logic [4:0] an;

    string  step_name [MAX_STEPS];
    logic   in_presence [MAX_STEPS];
    logic   in_vibration [MAX_STEPS];
    logic   in_feed [MAX_STEPS];
    logic   in_heal [MAX_STEPS];
    int     step_ticks [MAX_STEPS];
    level_t exp_lvl [MAX_STEPS][5];
    mood_t  exp_mood [MAX_STEPS];
    logic   exp_over [MAX_STEPS];
    logic   win_set [MAX_STEPS];
    time    win_lo [MAX_STEPS];
    logic   mood_seen [MAX_STEPS];
    string  level_name [5] = '{"hunger", "fun", "energy", "happy", "life"};

    int   step_count;
    int   total_ticks;
    logic steps_loaded;
    time  t0;
    int   cyc;

    // LCD capture state
    int    init_count;
    int    char_count;
    logic  in_line;
    text_t line_buf;
    time   line_time;

    pet_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .ready     (ready),
        .presence  (presence),
        .vibration (vibration),
        .feed      (feed),
        .heal      (heal),
        .rs        (rs),
        .rw        (rw),
        .e         (e),
        .data      (data),
        .seg       (seg),
        .an        (an)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_level(input string name, input string what,
                               input level_t expected, input level_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: %s expected %0d, got %0d", name, what, expected, actual);
            abort_run("Level shown on the display is wrong");
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: LCD byte expected %02h, got %02h", name, expected, actual);
            abort_run("LCD received a wrong byte");
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: %s expected %0b, got %0b", name, what, expected, actual);
            abort_run("A control flag has the wrong value");
        end
    endtask

    task automatic check_text(input string name, input text_t expected, input text_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: LCD line expected \"%s\", got \"%s\"", name, expected, actual);
            abort_run("LCD mood line is wrong");
        end
    endtask

    // Active low a to g, bit 0 is segment a
    function automatic level_t seg_to_level(input logic [6:0] pattern);
        case (pattern)
            7'b1000000: return 4'd0;
            7'b1111001: return 4'd1;
            7'b0100100: return 4'd2;
            7'b0110000: return 4'd3;
            7'b0011001: return 4'd4;
            7'b0010010: return 4'd5;
            default:    return 4'hF;
        endcase
    endfunction

    task automatic step_clk();
        @(posedge clk);
        cyc = cyc + 1;
    endtask

    task automatic load_steps();
        int    fd;
        int    n;
        string text;
        string name;
        int    p, v, f, h, t;
        int    l0, l1, l2, l3, l4;
        int    m, g;
        fd = $fopen("sim/pet_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open sim/pet_testdata.txt");
        end
        step_count = 0;
        total_ticks = 0;
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (n > 0 && text.len() > 1 && text.substr(0, 0) != "#") begin
                n = $sscanf(text, "%s %d %d %d %d %d %d %d %d %d %d %d %d",
                            name, p, v, f, h, t, l0, l1, l2, l3, l4, m, g);
                if (n != 13) begin
                    abort_run({"Malformed test data line: ", text});
                end
                if (step_count == MAX_STEPS) begin
                    abort_run("Test data holds too many steps");
                end
                step_name[step_count]    = name;
                in_presence[step_count]  = p[0];
                in_vibration[step_count] = v[0];
                in_feed[step_count]      = f[0];
                in_heal[step_count]      = h[0];
                step_ticks[step_count]   = t;
                exp_lvl[step_count][0]   = level_t'(l0);
                exp_lvl[step_count][1]   = level_t'(l1);
                exp_lvl[step_count][2]   = level_t'(l2);
                exp_lvl[step_count][3]   = level_t'(l3);
                exp_lvl[step_count][4]   = level_t'(l4);
                exp_mood[step_count]     = mood_t'(m);
                exp_over[step_count]     = g[0];
                total_ticks = total_ticks + t;
                step_count = step_count + 1;
            end
        end
        $fclose(fd);
    endtask

    // Gathers one full scan of the five digits and compares them
    task automatic check_display(input int idx);
        level_t     shown [5];
        logic [4:0] seen;
        int         wait_cnt;
        int         d;
        seen = '0;
        wait_cnt = 0;
        while (seen != 5'b11111) begin
            step_clk();
            wait_cnt = wait_cnt + 1;
            if (wait_cnt > 8 * SCAN_CYCLES) begin
                abort_run("Display scan did not light all five digits");
            end
            case (an)
                5'b11110: d = 0;
                5'b11101: d = 1;
                5'b11011: d = 2;
                5'b10111: d = 3;
                5'b01111: d = 4;
                default:  d = -1;
            endcase
            if (d >= 0) begin
                shown[d] = seg_to_level(seg);
                seen[d] = 1'b1;
            end
        end
        for (int k = 0; k < 5; k++) begin
            check_level(step_name[idx], level_name[k], exp_lvl[idx][k], shown[k]);
        end
    endtask

    // Every write is taken as e falls
    always @(negedge e) begin : lcd_capture
        int j;
        if (reset) begin
            check_flag("lcd", "rw", 1'b0, rw);
            if (init_count < INIT_CMD_COUNT) begin
                check_flag("lcd_init", "rs", 1'b0, rs);
                check_byte("lcd_init", INIT_BYTES[init_count], data);
                init_count = init_count + 1;
            end else if (!rs) begin
                if (in_line) begin
                    abort_run("LCD cursor command arrived inside a text line");
                end
                check_byte("lcd_cursor", CURSOR_CMD, data);
                // Mood was taken when e rose
                line_time = $time - time'(LCD_HALF_CYCLES * CLK_PERIOD);
                char_count = 0;
                in_line = 1'b1;
            end else begin
                if (!in_line) begin
                    abort_run("LCD text byte arrived without a cursor command");
                end
                line_buf[char_count] = data;
                char_count = char_count + 1;
                if (char_count == TEXT_LEN) begin
                    in_line = 1'b0;
                    for (j = 0; j < step_count; j++) begin
                        if (win_set[j] && !mood_seen[j] && line_time > win_lo[j] &&
                            line_time < win_lo[j] + TICK_TIME) begin
                            check_text(step_name[j], MOOD_TEXT[exp_mood[j]], line_buf);
                            mood_seen[j] = 1'b1;
                        end
                    end
                end
            end
        end
    end

    // Bound on the run from the total game time in the data
    initial begin : watchdog
        int limit;
        wait (steps_loaded);
        limit = total_ticks * TICK_CYCLES * 2 + 2000;
        repeat (limit) @(posedge clk);
        abort_run("Simulation timed out before all steps finished");
    end

    initial begin : stimulus
        int done;
        clk = 1'b0;
        reset = 1'b0;
        ready = 1'b1;
        presence = 1'b1;
        vibration = 1'b1;
        feed = 1'b1;
        heal = 1'b1;
        init_count = 0;
        char_count = 0;
        in_line = 1'b0;
        line_buf = '0;
        line_time = 0;
        steps_loaded = 1'b0;
        cyc = 0;
        t0 = 0;
        for (int i = 0; i < MAX_STEPS; i++) begin
            win_set[i] = 1'b0;
            mood_seen[i] = 1'b0;
            win_lo[i] = 0;
        end
        load_steps();
        steps_loaded = 1'b1;

        repeat (8) @(posedge clk);
        reset <= 1'b1;
        t0 = $time;
        cyc = 0;
        done = 0;

        for (int i = 0; i < step_count; i++) begin
            if (step_ticks[i] > 0) begin
                while (cyc < TICK_CYCLES * done + DRIVE_OFFSET) begin
                    step_clk();
                end
                presence  <= in_presence[i];
                vibration <= in_vibration[i];
                feed      <= in_feed[i];
                heal      <= in_heal[i];
                done = done + step_ticks[i];
            end
            // Levels hold from the last tick until the next one
            win_lo[i] = t0 + TICK_TIME * time'(done);
            win_set[i] = 1'b1;
            while (cyc < TICK_CYCLES * done + 2) begin
                step_clk();
            end
            check_display(i);
            check_flag(step_name[i], "game_over", exp_over[i], u_dut.needs_bus.game_over);
        end

        while (!mood_seen[step_count - 1]) begin
            step_clk();
        end
        for (int i = 0; i < step_count; i++) begin
            if (!mood_seen[i]) begin
                abort_run({"No LCD line showed the mood of step ", step_name[i]});
            end
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// File: src/pet_top.sv
module pet_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       ready,
    input  logic       presence,
    input  logic       vibration,
    input  logic       feed,
    input  logic       heal,
    output logic       rs,
    output logic       rw,
    output logic       e,
    output logic [7:0] data,
    output logic [6:0] seg,
    output logic [4:0] an
);

    // Levels shared by all three blocks
    pet_needs_if needs_bus ();

    pet_needs u_needs (
        .clk       (clk),
        .reset     (reset),
        .presence  (presence),
        .vibration (vibration),
        .feed      (feed),
        .heal      (heal),
        .needs     (needs_bus.owner)
    );

    lcd_mood_writer u_lcd (
        .clk   (clk),
        .reset (reset),
        .ready (ready),
        .needs (needs_bus.viewer),
        .rs    (rs),
        .rw    (rw),
        .e     (e),
        .data  (data)
    );

    seg_scan u_scan (
        .clk   (clk),
        .reset (reset),
        .needs (needs_bus.viewer),
        .seg   (seg),
        .an    (an)
    );

endmodule

// File: src/seg_scan.sv
module seg_scan (
    input  logic        clk,
    input  logic        reset,
    pet_needs_if.viewer needs,
    output logic [6:0]  seg,
    output logic [4:0]  an
);

    import pet_pkg::*;

    logic [$clog2(SCAN_CYCLES)-1:0] scan_cnt;
    logic [2:0] digit;
    level_t level;

    // Active low segments, bit 0 is a and bit 6 is g
    function automatic logic [6:0] seg_decode(input level_t value);
        case (value)
            4'd0:    seg_decode = 7'b1000000;
            4'd1:    seg_decode = 7'b1111001;
            4'd2:    seg_decode = 7'b0100100;
            4'd3:    seg_decode = 7'b0110000;
            4'd4:    seg_decode = 7'b0011001;
            4'd5:    seg_decode = 7'b0010010;
            default: seg_decode = 7'b1111111;
        endcase
    endfunction

    // Digit order hunger, fun, energy, happy, life
    always_comb begin
        case (digit)
            3'd0:    level = needs.hunger;
            3'd1:    level = needs.fun;
            3'd2:    level = needs.energy;
            3'd3:    level = needs.happy;
            default: level = needs.life;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            scan_cnt <= '0;
            digit    <= '0;
            seg      <= 7'b1111111;
            an       <= 5'b11111;
        end else begin
            if (int'(scan_cnt) == SCAN_CYCLES - 1) begin
                scan_cnt <= '0;
                digit    <= (digit == 3'd4) ? 3'd0 : digit + 1'b1;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            seg <= seg_decode(level);
            an  <= ~(5'b00001 << digit);
        end
    end

endmodule

// File: src/lcd_mood_writer.sv
module lcd_mood_writer (
    input  logic        clk,
    input  logic        reset,
    input  logic        ready,
    pet_needs_if.viewer needs,
    output logic        rs,
    output logic        rw,
    output logic        e,
    output logic [7:0]  data
);

    import pet_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_INIT,
        S_CURSOR,
        S_TEXT
    } state_t;

    state_t state;
    logic [$clog2(LCD_HALF_CYCLES)-1:0] half_cnt;
    logic phase;
    logic half_end;
    logic slot_start;
    logic [$clog2(LCD_INIT_LEN)-1:0] init_idx;
    logic [$clog2(TEXT_LEN)-1:0]     char_idx;
    mood_t mood;
    mood_t mood_q;

    // Write-only bus
    assign rw = 1'b0;

    // Mood from the levels, most urgent need wins
    always_comb begin
        if (needs.game_over) begin
            mood = MOOD_DEAD;
        end else if (needs.life <= LEVEL_LOW) begin
            mood = MOOD_SAD;
        end else if (needs.happy <= LEVEL_LOW) begin
            mood = MOOD_SICK;
        end else if (needs.hunger <= LEVEL_LOW) begin
            mood = MOOD_HUNGRY;
        end else if (needs.energy <= LEVEL_LOW) begin
            mood = MOOD_TIRED;
        end else if (needs.fun <= LEVEL_LOW) begin
            mood = MOOD_BORED;
        end else begin
            mood = MOOD_HAPPY;
        end
    end

    // Enable divider, phase high is the e-high half of a write slot
    assign half_end   = (int'(half_cnt) == LCD_HALF_CYCLES - 1);
    assign slot_start = half_end && !phase;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            half_cnt <= '0;
            phase    <= 1'b0;
        end else begin
            half_cnt <= half_end ? '0 : half_cnt + 1'b1;
            if (half_end) begin
                phase <= !phase;
            end
        end
    end

    // rs and data change only as e rises, the LCD latches on the fall
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= S_IDLE;
            init_idx <= '0;
            char_idx <= '0;
            mood_q   <= MOOD_HAPPY;
            rs       <= 1'b0;
            e        <= 1'b0;
            data     <= '0;
        end else if (slot_start) begin
            case (state)
                S_IDLE: begin
                    if (ready) begin
                        state <= S_INIT;
                    end
                end
                S_INIT: begin
                    rs   <= 1'b0;
                    e    <= 1'b1;
                    data <= LCD_INIT_CMDS[init_idx];
                    if (int'(init_idx) == LCD_INIT_LEN - 1) begin
                        init_idx <= '0;
                        state    <= S_CURSOR;
                    end else begin
                        init_idx <= init_idx + 1'b1;
                    end
                end
                S_CURSOR: begin
                    rs       <= 1'b0;
                    e        <= 1'b1;
                    data     <= LCD_LINE1_ADDR;
                    // Mood held for the whole line
                    mood_q   <= mood;
                    char_idx <= '0;
                    state    <= S_TEXT;
                end
                S_TEXT: begin
                    rs   <= 1'b1;
                    e    <= 1'b1;
                    data <= MOOD_TEXT[mood_q][char_idx];
                    if (int'(char_idx) == TEXT_LEN - 1) begin
                        state <= S_CURSOR;
                    end else begin
                        char_idx <= char_idx + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end else if (half_end) begin
            e <= 1'b0;
        end
    end

endmodule

// File: src/pet_needs.sv
module pet_needs (
    input  logic       clk,
    input  logic       reset,
    input  logic       presence,
    input  logic       vibration,
    input  logic       feed,
    input  logic       heal,
    pet_needs_if.owner needs
);

    import pet_pkg::*;

    logic [$clog2(TICK_CYCLES)-1:0] prescale;
    logic [$clog2(TICK_WRAP)-1:0]   tick_idx;
    logic tick;
    logic awake_tick;

    level_t hunger_n;
    level_t fun_n;
    level_t energy_n;
    level_t happy_n;
    level_t life_n;
    logic   game_over_n;

    // True on the last tick of each period
    // Index 0 never hits a period so nothing decays at the start
    function automatic logic period_hit(
        input logic [$clog2(TICK_WRAP)-1:0] idx,
        input int                           period
    );
        return (int'(idx) % period) == (period - 1);
    endfunction

    assign tick = (int'(prescale) == TICK_CYCLES - 1);

    // Game time base
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            prescale <= '0;
            tick_idx <= '0;
        end else begin
            prescale <= tick ? '0 : prescale + 1'b1;
            if (tick) begin
                tick_idx <= (int'(tick_idx) == TICK_WRAP - 1) ? '0 : tick_idx + 1'b1;
            end
        end
    end

    assign awake_tick = tick && presence && !needs.game_over;

    always_comb begin
        hunger_n = needs.hunger;
        fun_n    = needs.fun;
        energy_n = needs.energy;
        happy_n  = needs.happy;
        life_n   = needs.life;

        if (awake_tick) begin
            if (period_hit(tick_idx, HUNGER_PERIOD) && hunger_n != '0) begin
                hunger_n = hunger_n - 1'b1;
            end
            if (period_hit(tick_idx, FUN_PERIOD) && fun_n != '0) begin
                fun_n = fun_n - 1'b1;
            end
            if (period_hit(tick_idx, ENERGY_PERIOD) && energy_n != '0) begin
                energy_n = energy_n - 1'b1;
            end
            // Low needs wear down happiness and life
            if (period_hit(tick_idx, LIFE_PERIOD)) begin
                if (needs.fun <= LEVEL_LOW && happy_n != '0) begin
                    happy_n = happy_n - 1'b1;
                end
                if ((needs.hunger <= LEVEL_LOW || needs.energy <= LEVEL_LOW ||
                     needs.happy <= LEVEL_LOW) && life_n != '0) begin
                    life_n = life_n - 1'b1;
                end
            end
        end

        // Asleep, energy comes back first and then life
        if (tick && !presence && !needs.game_over) begin
            if (needs.energy < LEVEL_MAX) begin
                energy_n = needs.energy + 1'b1;
            end
            if (needs.energy == LEVEL_MAX && needs.life < LEVEL_MAX) begin
                life_n = needs.life + 1'b1;
            end
        end

        // Buttons only count while awake, later ones win
        if (awake_tick) begin
            if (!feed) begin
                hunger_n = LEVEL_MAX;
            end
            if (!vibration) begin
                fun_n = LEVEL_MAX;
                if (energy_n != '0) begin
                    energy_n = energy_n - 1'b1;
                end
            end
            if (!heal && needs.life < LEVEL_MAX && hunger_n != '0) begin
                life_n   = LEVEL_MAX;
                hunger_n = hunger_n - 1'b1;
            end
        end

        game_over_n = needs.game_over || (life_n == '0);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            needs.hunger    <= LEVEL_MAX;
            needs.fun       <= LEVEL_MAX;
            needs.energy    <= LEVEL_MAX;
            needs.happy     <= LEVEL_MAX;
            needs.life      <= LEVEL_MAX;
            needs.game_over <= 1'b0;
        end else begin
            needs.hunger    <= hunger_n;
            needs.fun       <= fun_n;
            needs.energy    <= energy_n;
            needs.happy     <= happy_n;
            needs.life      <= life_n;
            needs.game_over <= game_over_n;
        end
    end

endmodule

// File: src/pet_needs_if.sv
interface pet_needs_if;

    import pet_pkg::*;

    level_t hunger;
    level_t fun;
    level_t energy;
    level_t happy;
    level_t life;
    logic   game_over;

    // Need logic owns the levels
    modport owner (
        output hunger, fun, energy, happy, life, game_over
    );

    // LCD writer and display scan only look
    modport viewer (
        input hunger, fun, energy, happy, life, game_over
    );

endinterface

// File: src/pet_pkg.sv
package pet_pkg;

    // Need level, 0 is empty and 5 is full
    typedef logic [3:0] level_t;

    localparam level_t LEVEL_MAX = 4'd5;
    localparam level_t LEVEL_LOW = 4'd2;

    // Mood in priority order, most urgent first
    typedef enum logic [2:0] {
        MOOD_DEAD,
        MOOD_SAD,
        MOOD_SICK,
        MOOD_HUNGRY,
        MOOD_TIRED,
        MOOD_BORED,
        MOOD_HAPPY
    } mood_t;

    localparam int MOOD_COUNT = 7;

    // Game time base, tick length in clocks and decay periods in ticks
    localparam int TICK_CYCLES = 64;
    localparam int HUNGER_PERIOD = 8;
    localparam int FUN_PERIOD = 4;
    localparam int ENERGY_PERIOD = 16;
    localparam int LIFE_PERIOD = 8;
    localparam int TICK_WRAP = 16;

    // LCD bus timing
    localparam int LCD_HALF_CYCLES = 4;
    localparam int LCD_INIT_LEN = 3;

    // 8-bit bus with two lines, display on with cursor off, then clear
    localparam logic [0:LCD_INIT_LEN-1][7:0] LCD_INIT_CMDS = {8'h38, 8'h0C, 8'h01};
    localparam logic [7:0] LCD_LINE1_ADDR = 8'h84;

    localparam int TEXT_LEN = 12;

    // One line per mood, row index is the mood_t code
    localparam logic [0:MOOD_COUNT-1][0:TEXT_LEN-1][7:0] MOOD_TEXT = {
        "GAME OVER   ",
        "FEELING SAD ",
        "I FEEL SICK ",
        "SO HUNGRY   ",
        "VERY TIRED  ",
        "SO BORED    ",
        "HAPPY PET   "
    };

    // Display scan, clocks per digit
    localparam int SCAN_CYCLES = 8;

endpackage
